// File: flist.f
rtl/rv_isa_pkg.sv
rtl/rv_pipe_pkg.sv
rtl/rv_exec_stage.sv
rtl/rv_reg_ex_mem.sv
rtl/rv_mem_stage.sv
rtl/rv_credit_ctrl.sv
rtl/rv_backend_top.sv
bench/rv_backend_tb.sv

// File: Makefile
# Verilator build for the RISC-V back end testbench

VERILATOR  ?= verilator
TOP        ?= rv_backend_tb
FLIST      ?= flist.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary -j 0
LINT_FLAGS ?= -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)

// File: bench/rv_backend_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rv_backend_tb import rv_isa_pkg::*, rv_pipe_pkg::*;;

    localparam int PIPELINED   = 1;
    localparam int DMEM_WORDS  = 256;
    localparam int OUT_CREDITS = 4;
    localparam int MEM_BYTES   = 64;
    localparam int TIMEOUT     = 400;

    typedef logic [$clog2(OUT_CREDITS + 1)-1:0] credit_cnt_t;

    logic   clk;
    logic   rst_n;
    logic   in_valid;
    ex_op_t in_op;
    logic   in_credit;
    logic   out_valid;
    wb_t    out_wb;
    logic   out_credit;

    integer seed        = 32'h4ce3ff88;
    integer credit_seed = 32'h4ce3ff88;
    int     cycle;
    wb_t    exp_q[$];
    int     issue_q[$];
    logic [7:0] mem_bytes [MEM_BYTES];
    logic   written [MEM_BYTES];
    logic   slot_busy;
    logic   fast_return;
    int     seen;
    int     returned;
    int     credits_driven;
    int     sent;
    int     credits_back;
    int     withhold_until;

    rv_backend_top #(
        .PIPELINED   (PIPELINED),
        .DMEM_WORDS  (DMEM_WORDS),
        .OUT_CREDITS (OUT_CREDITS)
    ) rv_backend_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_wb     (out_wb),
        .out_credit (out_credit)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_wb(input wb_t got, input wb_t exp);
        if (got !== exp) begin
            fail_run($sformatf("ERROR out_wb got %h expected %h", got, exp));
        end
    endtask

    task automatic check_count(input credit_cnt_t got, input credit_cnt_t exp);
        if (got !== exp) begin
            fail_run($sformatf("ERROR credit count got %h expected %h", got, exp));
        end
    endtask

    // Reference ALU following the RV32I rules
    function automatic xlen_t alu_model(input alu_op_e op, input xlen_t a, input xlen_t b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            default:  return $signed(a) >>> b[4:0];
        endcase
    endfunction

    function automatic xlen_t rand_word();
        return $random(seed);
    endfunction

    // Checks the result port, the input credit and the output credit count
    always @(negedge clk) begin
        int issue;
        if (rst_n === 1'b1) begin
            check_count(rv_backend_top_inst.rv_credit_ctrl_inst.count,
                        credit_cnt_t'(OUT_CREDITS - seen + returned));
        end
        if (in_credit === 1'b1) begin
            if (!slot_busy) begin
                fail_run("in_credit pulsed while no operation sat in the input slot");
            end
            slot_busy = 1'b0;
            credits_back++;
        end
        if (out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                fail_run("out_valid pulsed with no operation pending");
            end
            check_wb(out_wb, exp_q.pop_front());
            issue = issue_q.pop_front();
            if (issue >= 0 && cycle != issue + 2) begin
                fail_run($sformatf("result sampled at edge %0d came out after edge %0d",
                                   issue, cycle));
            end
            seen++;
            if (seen - returned > OUT_CREDITS) begin
                fail_run("more results appeared than the consumer granted credits");
            end
        end
        if (out_credit === 1'b1) begin
            returned++;
        end
    end

    // Consumer returns one credit per drained result
    always @(posedge clk) begin
        if (rst_n && seen > credits_driven && cycle >= withhold_until &&
            (fast_return || ($random(credit_seed) & 3) == 0)) begin
            out_credit <= 1'b1;
            credits_driven++;
        end else begin
            out_credit <= 1'b0;
        end
    end

    task automatic send_op(input ex_op_t op, input wb_t exp, input logic check_lat);
        int n;
        n = 0;
        while (slot_busy) begin
            if (n == TIMEOUT) begin
                fail_run("timeout while waiting for in_credit");
            end
            n++;
            @(posedge clk);
        end
        in_valid  <= 1'b1;
        in_op     <= op;
        slot_busy = 1'b1;
        exp_q.push_back(exp);
        // The DUT samples in_valid on the next edge
        issue_q.push_back(check_lat ? cycle + 2 : -1);
        sent++;
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic alu_test(input int i, input logic check_lat);
        ex_op_t op;
        wb_t    exp;
        xlen_t  r;
        op          = '0;
        op.kind     = OP_ALU;
        op.alu_op   = alu_op_e'(i % 10);
        op.use_imm  = ((i / 10) % 2) == 1;
        op.rd       = reg_idx_t'(rand_word());
        op.rs1_data = rand_word();
        op.rs2_data = rand_word();
        r           = rand_word();
        op.imm      = {{20{r[11]}}, r[11:0]};
        exp.reg_write = 1'b1;
        exp.rd        = op.rd;
        exp.data      = alu_model(op.alu_op, op.rs1_data,
                                  op.use_imm ? op.imm : op.rs2_data);
        send_op(op, exp, check_lat);
    endtask

    // Memory operation of 1, 2 or 4 bytes on an aligned address
    // A negative base picks the address at random
    task automatic mem_test(input logic is_load, input int size, input int base);
        ex_op_t op;
        wb_t    exp;
        xlen_t  r;
        xlen_t  val;
        int     nbytes;
        int     addr;
        nbytes = 1 << size;
        if (base >= 0) begin
            addr = base;
        end else begin
            addr = int'(rand_word() & (MEM_BYTES - 1)) & ~(nbytes - 1);
        end
        r      = rand_word();
        op               = '0;
        op.kind          = is_load ? OP_LOAD : OP_STORE;
        op.mem_size      = mem_size_e'(size);
        op.load_unsigned = r[20];
        op.rd            = reg_idx_t'(r[25:21]);
        op.imm           = {{20{r[11]}}, r[11:0]};
        op.rs1_data      = xlen_t'(addr) - op.imm;
        op.rs2_data      = rand_word();
        val = '0;
        for (int i = 0; i < nbytes; i++) begin
            if (is_load) begin
                if (!written[addr + i]) begin
                    fail_run("load generated from an unwritten byte");
                end
                val[i*8 +: 8] = mem_bytes[addr + i];
            end else begin
                mem_bytes[addr + i] = op.rs2_data[i*8 +: 8];
                written[addr + i]   = 1'b1;
            end
        end
        if (is_load && size == 0) begin
            val = op.load_unsigned ? {24'd0, val[7:0]} : {{24{val[7]}}, val[7:0]};
        end else if (is_load && size == 1) begin
            val = op.load_unsigned ? {16'd0, val[15:0]} : {{16{val[15]}}, val[15:0]};
        end
        exp.reg_write = is_load;
        exp.rd        = op.rd;
        exp.data      = is_load ? val : xlen_t'(addr);
        send_op(op, exp, 1'b0);
    endtask

    task automatic mixed_test(input int count);
        int k;
        for (int i = 0; i < count; i++) begin
            k = int'(rand_word() & 32'h7fff);
            case (k % 3)
                0:       alu_test(k, 1'b0);
                1:       mem_test(1'b0, (k / 3) % 3, -1);
                default: mem_test(1'b1, (k / 3) % 3, -1);
            endcase
        end
    endtask

    initial begin
        int n;
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        in_op          = '0;
        out_credit     = 1'b0;
        cycle          = 0;
        slot_busy      = 1'b0;
        fast_return    = 1'b1;
        seen           = 0;
        returned       = 0;
        credits_driven = 0;
        sent           = 0;
        credits_back   = 0;
        withhold_until = 0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            written[i] = 1'b0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);

        // Every ALU op with register and immediate operands and a latency check
        for (int i = 0; i < 60; i++) begin
            alu_test(i, 1'b1);
        end

        // Fill the whole data region with words before the random mix
        fast_return = 1'b0;
        for (int a = 0; a < MEM_BYTES / 4; a++) begin
            mem_test(1'b0, 2, a * 4);
        end
        mixed_test(120);

        // Consumer holds its credits for a while
        withhold_until = cycle + 60;
        mixed_test(20);

        n = 0;
        while (exp_q.size() != 0 || returned != seen) begin
            if (n == TIMEOUT) begin
                fail_run("timeout while draining the remaining results");
            end
            n++;
            @(posedge clk);
        end
        if (credits_back != sent) begin
            fail_run($sformatf("ERROR in_credit count got %h expected %h", credits_back, sent));
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rv_backend_top.sv
`timescale 1ns/10ps
`default_nettype none

module rv_backend_top
    import rv_pipe_pkg::*;
#(
    parameter int PIPELINED   = 1,
    parameter int DMEM_WORDS  = 256,
    parameter int OUT_CREDITS = 4
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_valid,
    input  ex_op_t in_op,
    output logic   in_credit,
    output logic   out_valid,
    output wb_t    out_wb,
    input  logic   out_credit
);

    logic    stall;
    logic    ex_valid;
    ex_mem_t ex_mem_in;
    logic    mem_valid;
    ex_mem_t ex_mem_out;

    rv_exec_stage rv_exec_stage_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .in_credit (in_credit),
        .ex_valid  (ex_valid),
        .ex_mem    (ex_mem_in)
    );

    rv_reg_ex_mem #(
        .PIPELINED (PIPELINED)
    ) rv_reg_ex_mem_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .valid_ex   (ex_valid),
        .ex_mem_ex  (ex_mem_in),
        .valid_mem  (mem_valid),
        .ex_mem_mem (ex_mem_out)
    );

    rv_mem_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) rv_mem_stage_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .valid     (mem_valid),
        .ex_mem    (ex_mem_out),
        .out_valid (out_valid),
        .out_wb    (out_wb)
    );

    // Output back-pressure, sits beside the pipeline
    rv_credit_ctrl #(
        .OUT_CREDITS (OUT_CREDITS)
    ) rv_credit_ctrl_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_valid  (mem_valid),
        .out_valid  (out_valid),
        .out_credit (out_credit),
        .stall      (stall)
    );

endmodule

`default_nettype wire

// File: rtl/rv_credit_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module rv_credit_ctrl #(
    parameter int OUT_CREDITS = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic mem_valid,
    input  logic out_valid,
    input  logic out_credit,
    output logic stall
);

    localparam int CW = $clog2(OUT_CREDITS + 1);

    logic [CW-1:0] count;
    logic [CW-1:0] credits_free;

    // Consumer credits currently held, never above OUT_CREDITS
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= CW'(OUT_CREDITS);
        end else begin
            case ({out_valid, out_credit})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;
            endcase
        end
    end

    // A result on the port this cycle has already spent its credit
    assign credits_free = count - CW'(out_valid);

    // Hold the memory stage only when it has something to send
    assign stall = mem_valid && (credits_free == '0);

endmodule

`default_nettype wire

// File: rtl/rv_mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

module rv_mem_stage
    import rv_isa_pkg::*, rv_pipe_pkg::*;
#(
    parameter int DMEM_WORDS = 256
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    stall,
    input  logic    valid,
    input  ex_mem_t ex_mem,
    output logic    out_valid,
    output wb_t     out_wb
);

    localparam int AW = $clog2(DMEM_WORDS);

    xlen_t dmem [DMEM_WORDS];

    logic [AW-1:0] word_idx;
    logic [1:0]    byte_off;
    logic [3:0]    byte_en;
    xlen_t         store_data;
    xlen_t         rdata;
    logic [7:0]    lane_b;
    logic [15:0]   lane_h;
    funct3_t       ld_funct3;
    xlen_t         load_data;
    xlen_t         wb_data;
    logic          commit;

    // Word addressed, low two bits pick the byte lane
    assign word_idx = ex_mem.alu_result[AW+1:2];
    assign byte_off = ex_mem.alu_result[1:0];
    assign commit   = valid && !stall;

    // Byte enables and lane-replicated store data
    always_comb begin
        case (ex_mem.mem_size)
            SZ_BYTE: begin
                byte_en    = 4'b0001 << byte_off;
                store_data = {4{ex_mem.rs2_data[7:0]}};
            end
            SZ_HALF: begin
                byte_en    = byte_off[1] ? 4'b1100 : 4'b0011;
                store_data = {2{ex_mem.rs2_data[15:0]}};
            end
            default: begin
                byte_en    = 4'b1111;
                store_data = ex_mem.rs2_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (commit && ex_mem.mem_write) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    dmem[word_idx][i*8 +: 8] <= store_data[i*8 +: 8];
                end
            end
        end
    end

    // Asynchronous read, then lane extraction
    assign rdata = dmem[word_idx];

    always_comb begin
        case (byte_off)
            2'd0:    lane_b = rdata[7:0];
            2'd1:    lane_b = rdata[15:8];
            2'd2:    lane_b = rdata[23:16];
            default: lane_b = rdata[31:24];
        endcase
        lane_h = byte_off[1] ? rdata[31:16] : rdata[15:0];
    end

    // Rebuild the load funct3 to choose sign or zero extension
    assign ld_funct3 = {ex_mem.load_unsigned, ex_mem.mem_size};

    always_comb begin
        case (ld_funct3)
            F3_LB:   load_data = {{24{lane_b[7]}}, lane_b};
            F3_LH:   load_data = {{16{lane_h[15]}}, lane_h};
            F3_LBU:  load_data = {24'd0, lane_b};
            F3_LHU:  load_data = {16'd0, lane_h};
            default: load_data = rdata;
        endcase
    end

    // Stores report their address, ALU ops bypass the RAM
    assign wb_data = ex_mem.mem_read ? load_data : ex_mem.alu_result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= commit;
        end
    end

    always_ff @(posedge clk) begin
        if (commit) begin
            out_wb.reg_write <= ex_mem.reg_write;
            out_wb.rd        <= ex_mem.rd;
            out_wb.data      <= wb_data;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rv_reg_ex_mem.sv
`timescale 1ns/10ps
`default_nettype none

module rv_reg_ex_mem
    import rv_pipe_pkg::*;
#(
    parameter int PIPELINED = 1
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    stall,
    input  logic    valid_ex,
    input  ex_mem_t ex_mem_ex,
    output logic    valid_mem,
    output ex_mem_t ex_mem_mem
);

    if (PIPELINED != 0) begin : g_registered
        // Valid bit is the only control state here
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                valid_mem <= 1'b0;
            end else if (!stall) begin
                valid_mem <= valid_ex;
            end
        end

        // Record contents follow the valid bit and hold under stall
        always_ff @(posedge clk) begin
            if (!stall) begin
                ex_mem_mem <= ex_mem_ex;
            end
        end
    end else begin : g_passthrough
        // Stage removed, execute feeds memory in the same cycle
        assign valid_mem  = valid_ex;
        assign ex_mem_mem = ex_mem_ex;
    end

endmodule

`default_nettype wire

// File: rtl/rv_exec_stage.sv
`timescale 1ns/10ps
`default_nettype none

module rv_exec_stage
    import rv_isa_pkg::*, rv_pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    stall,
    input  logic    in_valid,
    input  ex_op_t  in_op,
    output logic    in_credit,
    output logic    ex_valid,
    output ex_mem_t ex_mem
);

    logic   slot_valid;
    ex_op_t slot_op;

    xlen_t      operand_b;
    logic [4:0] shamt;
    xlen_t      alu_result;
    xlen_t      eff_addr;

    // Single-entry input slot, upstream only sends while holding the credit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_valid <= 1'b0;
            in_credit  <= 1'b0;
        end else begin
            // The credit goes back once the slot hands its operation on
            in_credit <= slot_valid && !stall;
            if (slot_valid && !stall) begin
                slot_valid <= 1'b0;
            end
            if (in_valid) begin
                slot_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            slot_op <= in_op;
        end
    end

    // ALU
    always_comb begin
        operand_b = slot_op.use_imm ? slot_op.imm : slot_op.rs2_data;
        shamt     = operand_b[4:0];
        case (slot_op.alu_op)
            ALU_ADD:  alu_result = slot_op.rs1_data + operand_b;
            ALU_SUB:  alu_result = slot_op.rs1_data - operand_b;
            ALU_AND:  alu_result = slot_op.rs1_data & operand_b;
            ALU_OR:   alu_result = slot_op.rs1_data | operand_b;
            ALU_XOR:  alu_result = slot_op.rs1_data ^ operand_b;
            ALU_SLT: begin
                alu_result = {{(XLEN-1){1'b0}},
                              $signed(slot_op.rs1_data) < $signed(operand_b)};
            end
            ALU_SLTU: begin
                alu_result = {{(XLEN-1){1'b0}}, slot_op.rs1_data < operand_b};
            end
            ALU_SLL:  alu_result = slot_op.rs1_data << shamt;
            ALU_SRL:  alu_result = slot_op.rs1_data >> shamt;
            ALU_SRA:  alu_result = $signed(slot_op.rs1_data) >>> shamt;
            default:  alu_result = '0;
        endcase
    end

    // Loads and stores always address as rs1 + imm
    assign eff_addr = slot_op.rs1_data + slot_op.imm;

    always_comb begin
        ex_mem.reg_write     = slot_op.kind != OP_STORE;
        ex_mem.mem_read      = slot_op.kind == OP_LOAD;
        ex_mem.mem_write     = slot_op.kind == OP_STORE;
        ex_mem.mem_size      = slot_op.mem_size;
        ex_mem.load_unsigned = slot_op.load_unsigned;
        ex_mem.rd            = slot_op.rd;
        ex_mem.alu_result    = (slot_op.kind == OP_ALU) ? alu_result : eff_addr;
        ex_mem.rs2_data      = slot_op.rs2_data;
    end

    assign ex_valid = slot_valid;

endmodule

`default_nettype wire

// File: rtl/rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

    import rv_isa_pkg::*;

    // Decoded operation with its register operands already read
    typedef struct packed {
        op_kind_e  kind;
        alu_op_e   alu_op;
        logic      use_imm;
        mem_size_e mem_size;
        logic      load_unsigned;
        reg_idx_t  rd;
        xlen_t     rs1_data;
        xlen_t     rs2_data;
        xlen_t     imm;
    } ex_op_t;

    // Execute result heading to the memory stage
    typedef struct packed {
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        mem_size_e mem_size;
        logic      load_unsigned;
        reg_idx_t  rd;
        // ALU value, or effective address for loads and stores
        xlen_t     alu_result;
        // Store data
        xlen_t     rs2_data;
    } ex_mem_t;

    // Writeback record on the result port
    typedef struct packed {
        logic     reg_write;
        reg_idx_t rd;
        xlen_t    data;
    } wb_t;

endpackage

`default_nettype wire

// File: rtl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // Data path width, the pipeline records are built on this
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [2:0]      funct3_t;

    // Load funct3 codes, bit 2 selects zero extension
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    typedef enum logic [1:0] {
        OP_ALU,
        OP_LOAD,
        OP_STORE
    } op_kind_e;

    // Encoded as the low two bits of the load and store funct3
    typedef enum logic [1:0] {
        SZ_BYTE = 2'b00,
        SZ_HALF = 2'b01,
        SZ_WORD = 2'b10
    } mem_size_e;

endpackage

`default_nettype wire
